// File: run.sh
#!/bin/sh
# Build and run the read crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rdx_xbar -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rdx_xbar)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^TEST RESULT: PASS$'; then
  exit 0
fi
echo "Pass message not found"
exit 1

// File: source/rdx_bus_pkg.sv
`default_nettype none

// Widths and payload types shared by every port of the read crossbar
package rdx_bus_pkg;

  // Request address width in bits
  localparam int unsigned ADDR_W = 32;

  // Response data width in bits
  localparam int unsigned DATA_W = 32;

  // Request address as seen on initiator and target ports
  typedef logic [ADDR_W-1:0] addr_t;

  // Response data returned from a target or the error responder
  typedef logic [DATA_W-1:0] data_t;

  // Pattern returned with every decode error, easy to spot in waves
  localparam data_t DECERR_DATA = 32'hbad0_dec0;

endpackage

`default_nettype wire

// File: source/rdx_decerr_resp.sv
`timescale 1ns/1ps
`default_nettype none

// Answers reads that hit no address rule
// Holds at most one request, response follows one cycle after acceptance
module rdx_decerr_resp (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic req_valid_i,
  output logic req_ready_o,
  output logic rsp_valid_o,
  input  logic rsp_ready_i
);

  logic pending_q; // Request accepted, response not yet taken

  assign req_ready_o = !pending_q;
  assign rsp_valid_o = pending_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        pending_q <= 1'b1;
      end else if (rsp_valid_o && rsp_ready_i) begin
        pending_q <= 1'b0; // Ready again on the following cycle
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rdx_init_demux.sv
`timescale 1ns/1ps
`default_nettype none

// Initiator side of the crossbar
// Decodes the address, steers the request to one target or the error
// responder, then waits for that source's response
module rdx_init_demux
  import rdx_bus_pkg::*;
  import rdx_map_pkg::*;
#(
  parameter int unsigned NUM_TGT = 3
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Initiator request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  addr_t                req_addr_i,
  // Initiator response
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output data_t                rsp_data_o,
  output logic                 rsp_err_o,
  // Toward the target muxes
  output logic [NUM_TGT-1:0]   tgt_valid_o,
  input  logic [NUM_TGT-1:0]   tgt_ready_i,
  output addr_t                tgt_addr_o,
  input  logic [NUM_TGT-1:0]   tgt_rsp_valid_i,
  output logic [NUM_TGT-1:0]   tgt_rsp_ready_o,
  input  data_t [NUM_TGT-1:0]  tgt_rsp_data_i,
  input  logic [NUM_TGT-1:0]   tgt_rsp_err_i
);

  typedef enum logic {
    IDLE,
    WAIT_RSP
  } state_t;

  state_t   state_q;
  tgt_idx_t sel_q;   // Target locked at acceptance
  logic     err_q;   // Locked request went to the error responder

  tgt_idx_t dec_idx;
  logic     dec_hit;

  logic err_req_valid;
  logic err_req_ready;
  logic err_rsp_valid;
  logic err_rsp_ready;

  // First matching rule wins, regions do not overlap anyway
  always_comb begin
    dec_idx = '0;
    dec_hit = 1'b0;
    for (int k = 0; k < NUM_TGT; k++) begin
      if (!dec_hit && req_addr_i >= RULE_BASE[k] &&
          req_addr_i < RULE_BASE[k] + RULE_SIZE) begin
        dec_idx = tgt_idx_t'(k);
        dec_hit = 1'b1;
      end
    end
  end

  always_comb begin
    tgt_valid_o     = '0;
    tgt_rsp_ready_o = '0;
    err_req_valid   = 1'b0;
    err_rsp_ready   = 1'b0;
    req_ready_o     = 1'b0;
    rsp_valid_o     = 1'b0;
    if (state_q == IDLE) begin
      if (dec_hit) begin
        tgt_valid_o[dec_idx] = req_valid_i;
        req_ready_o          = tgt_ready_i[dec_idx];
      end else begin
        err_req_valid = req_valid_i;
        req_ready_o   = req_valid_i && err_req_ready; // Low while nothing is offered
      end
    end else if (err_q) begin
      rsp_valid_o   = err_rsp_valid;
      err_rsp_ready = rsp_ready_i;
    end else begin
      rsp_valid_o            = tgt_rsp_valid_i[sel_q];
      tgt_rsp_ready_o[sel_q] = rsp_ready_i;
    end
  end

  assign tgt_addr_o = req_addr_i;
  assign rsp_data_o = err_q ? DECERR_DATA : tgt_rsp_data_i[sel_q];
  assign rsp_err_o  = err_q || tgt_rsp_err_i[sel_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      sel_q   <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_valid_i && req_ready_o) begin
            state_q <= WAIT_RSP;
            sel_q   <= dec_idx;
            err_q   <= !dec_hit;
          end
        end
        WAIT_RSP: begin
          if (rsp_valid_o && rsp_ready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  rdx_decerr_resp u_decerr_resp (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (err_req_valid),
    .req_ready_o (err_req_ready),
    .rsp_valid_o (err_rsp_valid),
    .rsp_ready_i (err_rsp_ready)
  );

endmodule

`default_nettype wire

// File: source/rdx_map_pkg.sv
`default_nettype none

// Fixed address map, rule k selects target k
package rdx_map_pkg;

  import rdx_bus_pkg::*;

  // Number of address rules, one per target port
  localparam int unsigned MAP_RULES = 3;

  // Base address of each region
  localparam addr_t RULE_BASE [MAP_RULES] = '{
    32'h0000_0000,
    32'h0000_1000,
    32'h0000_2000
  };

  // All regions share one size, a hit needs base <= addr < base + size
  localparam addr_t RULE_SIZE = 32'h0000_1000;

  // Decoded target index
  typedef logic [1:0] tgt_idx_t;

endpackage

`default_nettype wire

// File: source/rdx_tgt_mux.sv
`timescale 1ns/1ps
`default_nettype none

// Target side of the crossbar
// Round-robin pick among initiators, one read in flight per target
module rdx_tgt_mux
  import rdx_bus_pkg::*;
#(
  parameter int unsigned NUM_INIT = 2
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // From the initiator demuxes
  input  logic [NUM_INIT-1:0]  init_valid_i,
  output logic [NUM_INIT-1:0]  init_ready_o,
  input  addr_t [NUM_INIT-1:0] init_addr_i,
  output logic [NUM_INIT-1:0]  init_rsp_valid_o,
  input  logic [NUM_INIT-1:0]  init_rsp_ready_i,
  // Target port
  output logic                 tgt_req_valid_o,
  input  logic                 tgt_req_ready_i,
  output addr_t                tgt_req_addr_o,
  input  logic                 tgt_rsp_valid_i,
  output logic                 tgt_rsp_ready_o
);

  localparam int unsigned IDX_W = (NUM_INIT > 1) ? $clog2(NUM_INIT) : 1;

  typedef logic [IDX_W-1:0] init_idx_t;

  typedef enum logic {
    IDLE,
    BUSY
  } state_t;

  state_t    state_q;
  init_idx_t rr_q;     // Search starts here
  init_idx_t owner_q;  // Initiator whose read is in flight

  init_idx_t gnt_idx;
  init_idx_t rr_nxt;
  logic      gnt_found;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned cand;
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    for (int unsigned k = 0; k < NUM_INIT; k++) begin
      cand = int'(rr_q) + k;
      if (cand >= NUM_INIT) cand = cand - NUM_INIT;
      if (!gnt_found && init_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = init_idx_t'(cand);
      end
    end
  end

  assign rr_nxt = (gnt_idx == init_idx_t'(NUM_INIT - 1)) ? '0 : gnt_idx + 1'b1;

  assign tgt_req_valid_o = (state_q == IDLE) && gnt_found;
  assign tgt_req_addr_o  = init_addr_i[gnt_idx];
  assign tgt_rsp_ready_o = (state_q == BUSY) && init_rsp_ready_i[owner_q];

  always_comb begin
    init_ready_o     = '0;
    init_rsp_valid_o = '0;
    if (state_q == IDLE) begin
      init_ready_o[gnt_idx] = gnt_found && tgt_req_ready_i;
    end else begin
      init_rsp_valid_o[owner_q] = tgt_rsp_valid_i; // Only the owner sees it
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      rr_q    <= '0;
      owner_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (gnt_found) begin
            if (tgt_req_ready_i) begin
              state_q <= BUSY;
              owner_q <= gnt_idx;
              rr_q    <= rr_nxt;   // Next search starts past the owner
            end else begin
              // Park the pointer on the stalled grant so that a late
              // requester cannot swap the address under a raised valid
              rr_q <= gnt_idx;
            end
          end
        end
        BUSY: begin
          if (tgt_rsp_valid_i && tgt_rsp_ready_o) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/rdx_xbar.sv
`timescale 1ns/1ps
`default_nettype none

// Read-only crossbar, NUM_INIT initiators to NUM_TGT targets
module rdx_xbar
  import rdx_bus_pkg::*;
  import rdx_map_pkg::*;
#(
  parameter int unsigned NUM_INIT = 2,
  parameter int unsigned NUM_TGT  = MAP_RULES  // One target per map rule
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Initiator ports
  input  logic [NUM_INIT-1:0]  init_req_valid_i,
  output logic [NUM_INIT-1:0]  init_req_ready_o,
  input  addr_t [NUM_INIT-1:0] init_req_addr_i,
  output logic [NUM_INIT-1:0]  init_rsp_valid_o,
  input  logic [NUM_INIT-1:0]  init_rsp_ready_i,
  output data_t [NUM_INIT-1:0] init_rsp_data_o,
  output logic [NUM_INIT-1:0]  init_rsp_err_o,
  // Target ports
  output logic [NUM_TGT-1:0]   tgt_req_valid_o,
  input  logic [NUM_TGT-1:0]   tgt_req_ready_i,
  output addr_t [NUM_TGT-1:0]  tgt_req_addr_o,
  input  logic [NUM_TGT-1:0]   tgt_rsp_valid_i,
  output logic [NUM_TGT-1:0]   tgt_rsp_ready_o,
  input  data_t [NUM_TGT-1:0]  tgt_rsp_data_i,
  input  logic [NUM_TGT-1:0]   tgt_rsp_err_i
);

  // Demux view, indexed [initiator][target]
  logic [NUM_INIT-1:0][NUM_TGT-1:0] dmx_req_valid;
  logic [NUM_INIT-1:0][NUM_TGT-1:0] dmx_req_ready;
  logic [NUM_INIT-1:0][NUM_TGT-1:0] dmx_rsp_valid;
  logic [NUM_INIT-1:0][NUM_TGT-1:0] dmx_rsp_ready;
  addr_t [NUM_INIT-1:0]             dmx_addr;      // Same address goes to every mux

  // Mux view, indexed [target][initiator]
  logic [NUM_TGT-1:0][NUM_INIT-1:0] mux_req_valid;
  logic [NUM_TGT-1:0][NUM_INIT-1:0] mux_req_ready;
  logic [NUM_TGT-1:0][NUM_INIT-1:0] mux_rsp_valid;
  logic [NUM_TGT-1:0][NUM_INIT-1:0] mux_rsp_ready;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init_demux
    rdx_init_demux #(
      .NUM_TGT (NUM_TGT)
    ) u_init_demux (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .req_valid_i     (init_req_valid_i[i]),
      .req_ready_o     (init_req_ready_o[i]),
      .req_addr_i      (init_req_addr_i[i]),
      .rsp_valid_o     (init_rsp_valid_o[i]),
      .rsp_ready_i     (init_rsp_ready_i[i]),
      .rsp_data_o      (init_rsp_data_o[i]),
      .rsp_err_o       (init_rsp_err_o[i]),
      .tgt_valid_o     (dmx_req_valid[i]),
      .tgt_ready_i     (dmx_req_ready[i]),
      .tgt_addr_o      (dmx_addr[i]),
      .tgt_rsp_valid_i (dmx_rsp_valid[i]),
      .tgt_rsp_ready_o (dmx_rsp_ready[i]),
      .tgt_rsp_data_i  (tgt_rsp_data_i),   // Data and err fan out to all demuxes
      .tgt_rsp_err_i   (tgt_rsp_err_i)
    );
  end

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_cross_init
    for (genvar j = 0; j < NUM_TGT; j++) begin : gen_cross_tgt
      assign mux_req_valid[j][i] = dmx_req_valid[i][j];
      assign dmx_req_ready[i][j] = mux_req_ready[j][i];
      assign dmx_rsp_valid[i][j] = mux_rsp_valid[j][i];
      assign mux_rsp_ready[j][i] = dmx_rsp_ready[i][j];
    end
  end

  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_tgt_mux
    rdx_tgt_mux #(
      .NUM_INIT (NUM_INIT)
    ) u_tgt_mux (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .init_valid_i     (mux_req_valid[j]),
      .init_ready_o     (mux_req_ready[j]),
      .init_addr_i      (dmx_addr),
      .init_rsp_valid_o (mux_rsp_valid[j]),
      .init_rsp_ready_i (mux_rsp_ready[j]),
      .tgt_req_valid_o  (tgt_req_valid_o[j]),
      .tgt_req_ready_i  (tgt_req_ready_i[j]),
      .tgt_req_addr_o   (tgt_req_addr_o[j]),
      .tgt_rsp_valid_i  (tgt_rsp_valid_i[j]),
      .tgt_rsp_ready_o  (tgt_rsp_ready_o[j])
    );
  end

endmodule

`default_nettype wire

// File: tests/rdx_xbar_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake rules on the outputs of the crossbar
module rdx_xbar_properties
  import rdx_bus_pkg::*;
#(
  parameter int unsigned NUM_INIT = 2,
  parameter int unsigned NUM_TGT  = 3
) (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic [NUM_INIT-1:0]  init_rsp_valid_o,
  input logic [NUM_INIT-1:0]  init_rsp_ready_i,
  input data_t [NUM_INIT-1:0] init_rsp_data_o,
  input logic [NUM_INIT-1:0]  init_rsp_err_o,
  input logic [NUM_TGT-1:0]   tgt_req_valid_o,
  input logic [NUM_TGT-1:0]   tgt_req_ready_i,
  input addr_t [NUM_TGT-1:0]  tgt_req_addr_o
);

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    // Response stays put until the initiator takes it
    rsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      init_rsp_valid_o[i] && !init_rsp_ready_i[i] |=> init_rsp_valid_o[i] &&
        $stable(init_rsp_data_o[i]) && $stable(init_rsp_err_o[i]))
      else $error("initiator %0d response dropped or changed before its transfer", i);
  end

  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_tgt
    req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_req_valid_o[j] && !tgt_req_ready_i[j] |=>
        tgt_req_valid_o[j] && $stable(tgt_req_addr_o[j]))
      else $error("target %0d request dropped or changed before its transfer", j);
  end

  reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !(|init_rsp_valid_o) && !(|tgt_req_valid_o))
    else $error("valid output high while reset is asserted");

endmodule

bind rdx_xbar rdx_xbar_properties #(
  .NUM_INIT (NUM_INIT),
  .NUM_TGT  (NUM_TGT)
) u_rdx_xbar_properties (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .init_rsp_valid_o (init_rsp_valid_o),
  .init_rsp_ready_i (init_rsp_ready_i),
  .init_rsp_data_o  (init_rsp_data_o),
  .init_rsp_err_o   (init_rsp_err_o),
  .tgt_req_valid_o  (tgt_req_valid_o),
  .tgt_req_ready_i  (tgt_req_ready_i),
  .tgt_req_addr_o   (tgt_req_addr_o)
);

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free running clock and a reset held low for the first cycles
module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 10,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1; // Released just after an edge
  end

endmodule

`default_nettype wire

// File: tests/tb_rdx_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rdx_xbar
  import rdx_bus_pkg::*;
  import rdx_map_pkg::*;
;

  localparam int unsigned NUM_INIT = 2;
  localparam int unsigned NUM_TGT  = MAP_RULES;
  // 22 reads, each well under 40 cycles even with contention and holds
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic clk;
  logic arst_n;

  logic [NUM_INIT-1:0]  init_req_valid;
  logic [NUM_INIT-1:0]  init_req_ready;
  addr_t [NUM_INIT-1:0] init_req_addr;
  logic [NUM_INIT-1:0]  init_rsp_valid;
  logic [NUM_INIT-1:0]  init_rsp_ready;
  data_t [NUM_INIT-1:0] init_rsp_data;
  logic [NUM_INIT-1:0]  init_rsp_err;
  logic [NUM_TGT-1:0]   tgt_req_valid;
  logic [NUM_TGT-1:0]   tgt_req_ready;
  addr_t [NUM_TGT-1:0]  tgt_req_addr;
  logic [NUM_TGT-1:0]   tgt_rsp_valid;
  logic [NUM_TGT-1:0]   tgt_rsp_ready;
  data_t [NUM_TGT-1:0]  tgt_rsp_data;
  logic [NUM_TGT-1:0]   tgt_rsp_err;

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cycle_cnt = 0;
  int unsigned tgt_req_cycles = 0; // Cycles with any target request raised

  tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  rdx_xbar #(.NUM_INIT(NUM_INIT), .NUM_TGT(NUM_TGT)) u_rdx_xbar (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .init_req_valid_i (init_req_valid),
    .init_req_ready_o (init_req_ready),
    .init_req_addr_i  (init_req_addr),
    .init_rsp_valid_o (init_rsp_valid),
    .init_rsp_ready_i (init_rsp_ready),
    .init_rsp_data_o  (init_rsp_data),
    .init_rsp_err_o   (init_rsp_err),
    .tgt_req_valid_o  (tgt_req_valid),
    .tgt_req_ready_i  (tgt_req_ready),
    .tgt_req_addr_o   (tgt_req_addr),
    .tgt_rsp_valid_i  (tgt_rsp_valid),
    .tgt_rsp_ready_o  (tgt_rsp_ready),
    .tgt_rsp_data_i   (tgt_rsp_data),
    .tgt_rsp_err_i    (tgt_rsp_err)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Target models with random accept and answer delays of 0 to 3 cycles
  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_tgt_model
    logic  req_ready;
    logic  rsp_valid;
    data_t rsp_data;

    assign tgt_req_ready[j] = req_ready;
    assign tgt_rsp_valid[j] = rsp_valid;
    assign tgt_rsp_data[j]  = rsp_data;
    assign tgt_rsp_err[j]   = 1'b0;

    initial begin
      logic [31:0] rng;
      addr_t       addr;
      rng       = 32'h93fe ^ j;
      req_ready = 1'b0;
      rsp_valid = 1'b0;
      rsp_data  = '0;
      forever begin
        @(negedge clk);
        if (arst_n && tgt_req_valid[j]) begin
          rng = xorshift32(rng);
          @(posedge clk);
          #1;
          repeat (rng[1:0]) begin
            @(posedge clk);
            #1;
          end
          req_ready = 1'b1;
          addr      = tgt_req_addr[j];
          @(posedge clk); // Request transfer
          #1;
          req_ready = 1'b0;
          rng = xorshift32(rng);
          repeat (rng[1:0]) begin
            @(posedge clk);
            #1;
          end
          rsp_valid = 1'b1;
          rsp_data  = addr ^ (data_t'(j) * 32'h1111_0000);
          @(negedge clk);
          while (!tgt_rsp_ready[j]) @(negedge clk);
          @(posedge clk); // Response transfer
          #1;
          rsp_valid = 1'b0;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (|tgt_req_valid) tgt_req_cycles++;
  end

  // Expected data from the address map, decode errors return the fixed pattern
  function automatic data_t expected_data(input addr_t addr);
    for (int k = 0; k < MAP_RULES; k++) begin
      if (addr >= RULE_BASE[k] && addr - RULE_BASE[k] < RULE_SIZE) begin
        return addr ^ (data_t'(k) * 32'h1111_0000);
      end
    end
    return DECERR_DATA;
  endfunction

  function automatic logic is_mapped(input addr_t addr);
    for (int k = 0; k < MAP_RULES; k++) begin
      if (addr >= RULE_BASE[k] && addr - RULE_BASE[k] < RULE_SIZE) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // One read from an initiator, response ready held low for hold cycles
  task automatic read_check(input string name, input int unsigned ini, input addr_t addr,
                            input int unsigned hold);
    data_t first;
    @(posedge clk);
    #1;
    init_req_valid[ini] = 1'b1;
    init_req_addr[ini]  = addr;
    @(negedge clk);
    while (!init_req_ready[ini]) @(negedge clk);
    @(posedge clk);
    #1;
    init_req_valid[ini] = 1'b0;
    @(negedge clk);
    while (!init_rsp_valid[ini]) @(negedge clk);
    first = init_rsp_data[ini];
    repeat (hold) begin
      @(negedge clk);
      check({name, " valid held"}, 32'd1, {31'd0, init_rsp_valid[ini]});
      check({name, " data held"}, first, init_rsp_data[ini]);
    end
    @(posedge clk);
    #1;
    init_rsp_ready[ini] = 1'b1;
    @(negedge clk);
    check({name, " data"}, expected_data(addr), init_rsp_data[ini]);
    check({name, " err"}, {31'd0, !is_mapped(addr)}, {31'd0, init_rsp_err[ini]});
    @(posedge clk);
    #1;
    init_rsp_ready[ini] = 1'b0;
  endtask

  task automatic cover_all_regions();
    for (int unsigned i = 0; i < NUM_INIT; i++) begin
      for (int unsigned t = 0; t < NUM_TGT; t++) begin
        read_check("all_regions", i, RULE_BASE[t] + addr_t'(16 * (i + 1) + 4 * t), 0);
      end
    end
  endtask

  task automatic decode_error_reads();
    int unsigned seen;
    seen = tgt_req_cycles;
    read_check("unmapped", 0, 32'h0000_8000, 0);
    read_check("unmapped", 1, 32'h0000_3004, 2);
    check("unmapped target requests", seen, tgt_req_cycles);
  endtask

  task automatic series_on_target(input int unsigned ini, input addr_t base);
    for (int n = 0; n < 5; n++) read_check("same_target", ini, base + addr_t'(4 * n), 0);
  endtask

  task automatic contend_same_target();
    fork
      series_on_target(0, 32'h0000_1100);
      series_on_target(1, 32'h0000_1200);
    join
  endtask

  // Idle muxes pass both requests to their targets in the cycle they are raised
  task automatic watch_parallel_start();
    @(posedge clk);
    @(negedge clk);
    check("parallel both targets requested", 32'd3,
          {30'd0, tgt_req_valid[2], tgt_req_valid[0]});
  endtask

  task automatic parallel_targets();
    fork
      read_check("parallel", 0, 32'h0000_0040, 0);
      read_check("parallel", 1, 32'h0000_2080, 0);
      watch_parallel_start();
    join
  endtask

  task automatic hold_response();
    fork
      read_check("backpressure", 0, 32'h0000_2abc, 6);
      read_check("backpressure other", 1, 32'h0000_0c00, 0); // Other target runs freely
    join
  endtask

  initial begin
    init_req_valid = '0;
    init_req_addr  = '0;
    init_rsp_ready = '0;
    wait (arst_n == 1'b1);
    @(posedge clk);
    cover_all_regions();
    decode_error_reads();
    contend_same_target();
    parallel_targets();
    hold_response();
    repeat (5) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, a read never completed", cycle_cnt);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/rdx_bus_pkg.sv
source/rdx_map_pkg.sv
source/rdx_decerr_resp.sv
source/rdx_init_demux.sv
source/rdx_tgt_mux.sv
source/rdx_xbar.sv
tests/tb_clk_gen.sv
tests/rdx_xbar_properties.sv
tests/tb_rdx_xbar.sv
